// File: common/snowball_pkg.sv
`default_nettype none

package snowball_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // ------------------------------
  // cache geometry
  // ------------------------------
  localparam int CACHE_IDX_W   = 4;                 // 16 one-word lines
  localparam int CACHE_LINES   = 1 << CACHE_IDX_W;
  localparam int CACHE_IDX_LSB = 2;                 // index is addr[5:2]
  localparam int CACHE_TAG_LSB = 6;                 // tag is paddr[31:6]
  localparam int CACHE_TAG_W   = ADDR_W - CACHE_TAG_LSB;

  // ------------------------------
  // tlb geometry
  // ------------------------------
  localparam int PAGE_W      = 16;                  // page number is addr[31:16]
  localparam int PAGE_LSB    = ADDR_W - PAGE_W;
  localparam int TLB_IDX_W   = 4;                   // low bits of the virtual page
  localparam int TLB_ENTRIES = 1 << TLB_IDX_W;

  // memory port credits
  localparam int MEM_CREDITS = 2;
  localparam int CRED_W      = $clog2(MEM_CREDITS + 1);

  // controller states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOOKUP = 2'd1;          // array outputs valid
  localparam logic [1:0] ST_ISSUE  = 2'd2;          // waiting for a credit
  localparam logic [1:0] ST_WAIT   = 2'd3;          // read data outstanding

  // tlb load word, raw on the cpu side, split in the tlb
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [PAGE_W-1:0] vtag;
      logic [PAGE_W-1:0] ptag;
    } entry;
  } tlb_word_u;

endpackage

`default_nettype wire

// File: common/lookup_if.sv
`timescale 1ns/10ps
`default_nettype none

// ------------------------------
// controller <-> cache array
// ------------------------------
interface cache_lookup_if import snowball_pkg::*; ();
  logic                   line_valid;   // registered lookup result
  logic [CACHE_TAG_W-1:0] line_tag;
  logic [DATA_W-1:0]      line_data;
  logic                   fill_we;      // fill or write-hit update
  logic [CACHE_IDX_W-1:0] fill_idx;
  logic [CACHE_TAG_W-1:0] fill_tag;
  logic [DATA_W-1:0]      fill_data;

  modport array (
    output line_valid, line_tag, line_data,
    input  fill_we, fill_idx, fill_tag, fill_data
  );

  modport ctrl (
    input  line_valid, line_tag, line_data,
    output fill_we, fill_idx, fill_tag, fill_data
  );
endinterface

// ------------------------------
// controller <-> tlb
// ------------------------------
interface tlb_lookup_if import snowball_pkg::*; ();
  logic [PAGE_W-1:0]    ptag;           // physical page, or vpage when bypassed
  logic                 fault;
  logic                 load_we;
  logic [TLB_IDX_W-1:0] load_idx;
  tlb_word_u            load_word;

  modport tlb (
    output ptag, fault,
    input  load_we, load_idx, load_word
  );

  modport ctrl (
    input  ptag, fault,
    output load_we, load_idx, load_word
  );
endinterface

`default_nettype wire

// File: cache/cache_array.sv
`timescale 1ns/10ps
`default_nettype none

module cache_array import snowball_pkg::*; (
  input  wire                   CPU_CLK,
  input  wire                   RST_CPU,
  input  wire                   req_fire,
  input  wire [CACHE_IDX_W-1:0] req_idx,
  cache_lookup_if.array         lk
);

  logic [CACHE_TAG_W-1:0] tag_mem  [CACHE_LINES];
  logic [DATA_W-1:0]      data_mem [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;

  logic fwd;

  // a fill to the line being looked up wins over the stored copy
  assign fwd = lk.fill_we && (lk.fill_idx == req_idx);

  // ------------------------------
  // tag and data storage
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (lk.fill_we)
    begin
      tag_mem[lk.fill_idx]  <= lk.fill_tag;
      data_mem[lk.fill_idx] <= lk.fill_data;
    end
    if (req_fire)
    begin
      if (fwd)
      begin
        lk.line_tag  <= lk.fill_tag;
        lk.line_data <= lk.fill_data;
      end
      else
      begin
        lk.line_tag  <= tag_mem[req_idx];
        lk.line_data <= data_mem[req_idx];
      end
    end
  end

  // valid bits
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      valid_q       <= '0;
      lk.line_valid <= 1'b0;
    end
    else
    begin
      if (lk.fill_we)
        valid_q[lk.fill_idx] <= 1'b1;
      if (req_fire)
        lk.line_valid <= fwd || valid_q[req_idx];
    end
  end

endmodule

`default_nettype wire

// File: cache/tlb_array.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_array import snowball_pkg::*; (
  input  wire              CPU_CLK,
  input  wire              RST_CPU,
  input  wire              req_fire,
  input  wire [PAGE_W-1:0] req_vpage,
  input  wire              vmem_en,
  tlb_lookup_if.tlb        lk
);

  logic [PAGE_W-1:0]      vtag_mem [TLB_ENTRIES];
  logic [PAGE_W-1:0]      ptag_mem [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] loaded_q;        // entry written since reset

  logic [PAGE_W-1:0] vtag_q;
  logic [PAGE_W-1:0] ptag_q;
  logic [PAGE_W-1:0] vpage_q;
  logic              hit_loaded_q;
  logic              vmem_q;

  // ------------------------------
  // storage and registered lookup
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (lk.load_we)
    begin
      vtag_mem[lk.load_idx] <= lk.load_word.entry.vtag;
      ptag_mem[lk.load_idx] <= lk.load_word.entry.ptag;
    end
    if (req_fire)
    begin
      vtag_q  <= vtag_mem[req_vpage[TLB_IDX_W-1:0]];
      ptag_q  <= ptag_mem[req_vpage[TLB_IDX_W-1:0]];
      vpage_q <= req_vpage;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      loaded_q     <= '0;
      hit_loaded_q <= 1'b0;
      vmem_q       <= 1'b0;
    end
    else
    begin
      if (lk.load_we)
        loaded_q[lk.load_idx] <= 1'b1;
      if (req_fire)
      begin
        hit_loaded_q <= loaded_q[req_vpage[TLB_IDX_W-1:0]];
        vmem_q       <= vmem_en;             // mode sampled with the request
      end
    end
  end

  // bypass when translation is off
  assign lk.ptag  = vmem_q ? ptag_q : vpage_q;
  assign lk.fault = vmem_q && (!hit_loaded_q || (vtag_q != vpage_q));

endmodule

`default_nettype wire

// File: src/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl import snowball_pkg::*; (
  input  wire               CPU_CLK,
  input  wire               RST_CPU,
  input  wire               cpu_req,
  input  wire               cpu_we,
  input  wire               cpu_tlb_we,
  input  wire               cache_inhibit,
  input  wire  [ADDR_W-1:0] cpu_addr,
  input  wire  [DATA_W-1:0] cpu_wdata,
  output logic              busy,
  output logic              cpu_rsp_valid,
  output logic              cpu_fault,
  output logic [DATA_W-1:0] cpu_rdata,
  output logic              req_fire,
  output logic              mem_req,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  wire               mem_credit,
  input  wire               mem_rsp_valid,
  input  wire  [DATA_W-1:0] mem_rsp_data,
  cache_lookup_if.ctrl      clk,
  tlb_lookup_if.ctrl        tlk
);

  logic [1:0]        state;
  logic [CRED_W-1:0] cred_cnt;
  logic              rd_out;              // one read in flight at most

  // pending request
  logic              pend_we;
  logic              pend_tlb;
  logic              pend_inh;
  logic [ADDR_W-1:0] pend_addr;
  logic [DATA_W-1:0] pend_wdata;

  logic [ADDR_W-1:0] phys_addr;
  logic              hit;
  logic              need_mem;
  logic              cred_ok;
  logic              issue_now;
  logic              rsp_data;

  assign busy     = (state != ST_IDLE);
  assign req_fire = cpu_req && !busy;

  // tlb loads go straight through on the accept edge
  assign tlk.load_we       = req_fire && cpu_tlb_we;
  assign tlk.load_idx      = cpu_addr[PAGE_LSB +: TLB_IDX_W];
  assign tlk.load_word.raw = cpu_wdata;

  // ------------------------------
  // hit / miss / fault combine
  // ------------------------------
  assign phys_addr = {tlk.ptag, pend_addr[PAGE_LSB-1:0]};
  assign hit       = clk.line_valid && !pend_inh && !tlk.fault &&
                     (clk.line_tag == phys_addr[ADDR_W-1:CACHE_TAG_LSB]);
  assign need_mem  = (state == ST_LOOKUP) && !pend_tlb && !tlk.fault &&
                     (pend_we || !hit);

  assign cred_ok    = (cred_cnt != '0) && (pend_we || !rd_out);
  assign issue_now  = cred_ok && (need_mem || (state == ST_ISSUE));
  assign rsp_data   = (state == ST_WAIT) && mem_rsp_valid && rd_out;

  // ------------------------------
  // control state
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state         <= ST_IDLE;
      cred_cnt      <= CRED_W'(MEM_CREDITS);
      rd_out        <= 1'b0;
      cpu_rsp_valid <= 1'b0;
      cpu_fault     <= 1'b0;
      mem_req       <= 1'b0;
      clk.fill_we   <= 1'b0;
    end
    else
    begin
      cpu_rsp_valid <= 1'b0;
      clk.fill_we   <= 1'b0;
      mem_req       <= issue_now;                       // single-cycle pulse
      cred_cnt      <= cred_cnt - CRED_W'(mem_req) + CRED_W'(mem_credit);
      if (issue_now && !pend_we)
        rd_out <= 1'b1;
      else if (mem_rsp_valid)
        rd_out <= 1'b0;

      case (state)
        ST_IDLE:
          if (req_fire)
            state <= ST_LOOKUP;
        ST_LOOKUP, ST_ISSUE:
        begin
          if (state == ST_LOOKUP)
          begin
            cpu_fault <= tlk.fault && !pend_tlb;
            if (pend_we && hit)
              clk.fill_we <= 1'b1;                      // write hit update
          end
          if (((state == ST_LOOKUP) && !need_mem) || (issue_now && pend_we))
          begin
            state         <= ST_IDLE;
            cpu_rsp_valid <= 1'b1;
          end
          else if (issue_now)
            state <= ST_WAIT;
          else
            state <= ST_ISSUE;                          // no credit yet
        end
        default:
          if (rsp_data)
          begin
            state         <= ST_IDLE;
            cpu_rsp_valid <= 1'b1;
            clk.fill_we   <= !pend_inh;
          end
      endcase
    end
  end

  // ------------------------------
  // payload
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (req_fire)
    begin
      pend_we    <= cpu_we && !cpu_tlb_we;
      pend_tlb   <= cpu_tlb_we;
      pend_inh   <= cache_inhibit;
      pend_addr  <= cpu_addr;
      pend_wdata <= cpu_wdata;
    end
    if (state == ST_LOOKUP)
    begin
      cpu_rdata     <= clk.line_data;
      clk.fill_idx  <= phys_addr[CACHE_IDX_LSB +: CACHE_IDX_W];
      clk.fill_tag  <= phys_addr[ADDR_W-1:CACHE_TAG_LSB];
      clk.fill_data <= pend_wdata;
    end
    else if (rsp_data)
    begin
      cpu_rdata     <= mem_rsp_data;
      clk.fill_data <= mem_rsp_data;
    end
    if (issue_now)
    begin
      mem_we    <= pend_we;
      mem_addr  <= phys_addr;
      mem_wdata <= pend_wdata;
    end
  end

endmodule

`default_nettype wire

// File: src/snowball_cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module snowball_cache_top import snowball_pkg::*; (
  input  wire               CPU_CLK,
  input  wire               RST_CPU,
  input  wire               vmem_en,
  input  wire               cache_inhibit,
  // cpu side
  input  wire               cpu_req,
  input  wire               cpu_we,
  input  wire               cpu_tlb_we,
  input  wire  [ADDR_W-1:0] cpu_addr,
  input  wire  [DATA_W-1:0] cpu_wdata,
  output logic              busy,
  output logic              cpu_rsp_valid,
  output logic              cpu_fault,
  output logic [DATA_W-1:0] cpu_rdata,
  // memory side
  output logic              mem_req,
  output logic              mem_we,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  wire               mem_credit,
  input  wire               mem_rsp_valid,
  input  wire  [DATA_W-1:0] mem_rsp_data
);

  logic req_fire;

  cache_lookup_if c_lk ();
  tlb_lookup_if   t_lk ();

  // both arrays look up on the same edge
  cache_array u_cache_array (
    .CPU_CLK  (CPU_CLK),
    .RST_CPU  (RST_CPU),
    .req_fire (req_fire),
    .req_idx  (cpu_addr[CACHE_IDX_LSB +: CACHE_IDX_W]),
    .lk       (c_lk.array)
  );

  tlb_array u_tlb_array (
    .CPU_CLK   (CPU_CLK),
    .RST_CPU   (RST_CPU),
    .req_fire  (req_fire),
    .req_vpage (cpu_addr[PAGE_LSB +: PAGE_W]),
    .vmem_en   (vmem_en),
    .lk        (t_lk.tlb)
  );

  cache_ctrl u_cache_ctrl (
    .CPU_CLK       (CPU_CLK),
    .RST_CPU       (RST_CPU),
    .cpu_req       (cpu_req),
    .cpu_we        (cpu_we),
    .cpu_tlb_we    (cpu_tlb_we),
    .cache_inhibit (cache_inhibit),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .busy          (busy),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_fault     (cpu_fault),
    .cpu_rdata     (cpu_rdata),
    .req_fire      (req_fire),
    .mem_req       (mem_req),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .clk           (c_lk.ctrl),
    .tlk           (t_lk.ctrl)
  );

endmodule

`default_nettype wire

// File: test/cache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cache_checker import snowball_pkg::*; (
  input wire              CPU_CLK,
  input wire              RST_CPU,
  input wire              mem_req,
  input wire              busy,
  input wire              cpu_rsp_valid,
  input wire [CRED_W-1:0] cred_cnt
);

  // ------------------------------
  // credit protocol
  // ------------------------------
  no_req_without_credit: assert property (
    @(posedge CPU_CLK) disable iff (RST_CPU) mem_req |-> (cred_cnt != '0))
    else $error("mem_req raised while no credit is held");

  credit_bound: assert property (
    @(posedge CPU_CLK) disable iff (RST_CPU) cred_cnt <= CRED_W'(MEM_CREDITS))
    else $error("credit count above the granted number");

  // cpu side
  quiet_after_reset: assert property (
    @(posedge CPU_CLK) $fell(RST_CPU) |-> (!cpu_rsp_valid && !busy))
    else $error("cpu_rsp_valid or busy high right after reset");

  rsp_single_cycle: assert property (
    @(posedge CPU_CLK) disable iff (RST_CPU) cpu_rsp_valid |=> !cpu_rsp_valid)
    else $error("cpu_rsp_valid held longer than one cycle");

endmodule

bind cache_ctrl cache_checker u_checker (
  .CPU_CLK       (CPU_CLK),
  .RST_CPU       (RST_CPU),
  .mem_req       (mem_req),
  .busy          (busy),
  .cpu_rsp_valid (cpu_rsp_valid),
  .cred_cnt      (cred_cnt)
);

`default_nettype wire

// File: test/cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_tb import snowball_pkg::*; ();

  localparam logic [1:0] OP_RD  = 2'd0;
  localparam logic [1:0] OP_WR  = 2'd1;
  localparam logic [1:0] OP_TLB = 2'd2;
  localparam int         TIMEOUT = 200;      // cycles allowed per wait

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        vmem;
    logic        inh;
    logic [31:0] exp_data;
    logic        exp_fault;
    int          exp_reads;                  // new memory reads for this row
  } row_t;

  logic        CPU_CLK;
  logic        RST_CPU;
  logic        vmem_en;
  logic        cache_inhibit;
  logic        cpu_req;
  logic        cpu_we;
  logic        cpu_tlb_we;
  logic [31:0] cpu_addr;
  logic [31:0] cpu_wdata;
  logic        busy;
  logic        cpu_rsp_valid;
  logic        cpu_fault;
  logic [31:0] cpu_rdata;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_credit    = 1'b0;
  logic        mem_rsp_valid = 1'b0;
  logic [31:0] mem_rsp_data  = '0;

  row_t rows [$];
  int   err_cnt = 0;

  snowball_cache_top DUT (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #50 CPU_CLK = ~CPU_CLK;
  end

  // ------------------------------
  // memory model
  // ------------------------------
  logic [31:0] mem_words [logic [31:0]];
  int          credit_due [$];               // cycle each credit comes back
  int          cycle_cnt = 0;
  int          read_cnt  = 0;
  logic [31:0] lfsr_q    = 32'h544b6a55;

  function automatic logic [31:0] mem_pattern(input logic [31:0] addr);
    return addr ^ 32'h5A5A0000;
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge CPU_CLK)
  begin : memory
    logic [3:0] delay;
    cycle_cnt     <= cycle_cnt + 1;
    mem_rsp_valid <= 1'b0;
    mem_credit    <= 1'b0;
    if (mem_req)
    begin
      delay = '0;
      for (int i = 0; i < 4; i++)
      begin
        lfsr_q = lfsr_step(lfsr_q);
        delay  = {delay[2:0], lfsr_q[0]};
      end
      credit_due.push_back(cycle_cnt + 1 + int'(delay));
      if (mem_we)
        mem_words[mem_addr] = mem_wdata;
      else
      begin
        read_cnt      <= read_cnt + 1;
        mem_rsp_valid <= 1'b1;                 // reads answered in order
        mem_rsp_data  <= mem_words.exists(mem_addr) ? mem_words[mem_addr]
                                                    : mem_pattern(mem_addr);
      end
    end
    if (credit_due.size() != 0 && credit_due[0] <= cycle_cnt)
    begin
      mem_credit <= 1'b1;                      // one credit per cycle
      void'(credit_due.pop_front());
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic add_row(input logic [1:0] op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic vmem, input logic inh,
                         input logic [31:0] exp_data, input logic exp_fault,
                         input int exp_reads);
    rows.push_back('{op, addr, wdata, vmem, inh, exp_data, exp_fault, exp_reads});
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_idle(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok; n++)
    begin
      @(posedge CPU_CLK);
      ok = !busy;
    end
  endtask

  task automatic wait_response(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT && !ok; n++)
    begin
      @(posedge CPU_CLK);
      ok = cpu_rsp_valid;
    end
  endtask

  // ------------------------------
  // stimulus and results
  // ------------------------------
  initial
  begin
    tlb_word_u tlb_word;
    row_t      r;
    bit        ok;
    bit        timed_out;
    int        errs_before;
    int        reads_before;
    int        pass_cnt;
    int        fail_cnt;
    RST_CPU       = 1'b1;
    vmem_en       = 1'b0;
    cache_inhibit = 1'b0;
    cpu_req       = 1'b0;
    cpu_we        = 1'b0;
    cpu_tlb_we    = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    timed_out     = 1'b0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    tlb_word.entry.vtag = 16'h0003;
    tlb_word.entry.ptag = 16'h0012;

    // miss then hit
    add_row(OP_RD, 32'h0000_1044, '0, 1'b0, 1'b0, mem_pattern(32'h0000_1044), 1'b0, 1);
    add_row(OP_RD, 32'h0000_1044, '0, 1'b0, 1'b0, mem_pattern(32'h0000_1044), 1'b0, 0);
    // write-through on a hit and on a miss
    add_row(OP_WR, 32'h0000_1044, 32'hCAFE_0001, 1'b0, 1'b0, '0, 1'b0, 0);
    add_row(OP_RD, 32'h0000_1044, '0, 1'b0, 1'b0, 32'hCAFE_0001, 1'b0, 0);
    // inhibited read goes to memory for the written word
    add_row(OP_RD, 32'h0000_1044, '0, 1'b0, 1'b1, 32'hCAFE_0001, 1'b0, 1);
    add_row(OP_WR, 32'h0000_2048, 32'hBEEF_0002, 1'b0, 1'b0, '0, 1'b0, 0);
    add_row(OP_RD, 32'h0000_2048, '0, 1'b0, 1'b0, 32'hBEEF_0002, 1'b0, 1);
    // translation
    add_row(OP_TLB, 32'h0003_0000, tlb_word.raw, 1'b1, 1'b0, '0, 1'b0, 0);
    add_row(OP_RD, 32'h0003_004C, '0, 1'b1, 1'b0,
            mem_pattern({tlb_word.entry.ptag, 16'h004C}), 1'b0, 1);
    add_row(OP_RD, 32'h0003_004C, '0, 1'b1, 1'b0,
            mem_pattern({tlb_word.entry.ptag, 16'h004C}), 1'b0, 0);
    add_row(OP_RD, 32'h0005_0050, '0, 1'b1, 1'b0, '0, 1'b1, 0);   // entry never loaded
    add_row(OP_RD, 32'h0013_0054, '0, 1'b1, 1'b0, '0, 1'b1, 0);   // vtag mismatch
    // cache inhibit
    add_row(OP_RD, 32'h0000_3058, '0, 1'b0, 1'b1, mem_pattern(32'h0000_3058), 1'b0, 1);
    add_row(OP_RD, 32'h0000_3058, '0, 1'b0, 1'b1, mem_pattern(32'h0000_3058), 1'b0, 1);
    add_row(OP_RD, 32'h0000_3058, '0, 1'b0, 1'b0, mem_pattern(32'h0000_3058), 1'b0, 1);
    add_row(OP_RD, 32'h0000_3058, '0, 1'b0, 1'b0, mem_pattern(32'h0000_3058), 1'b0, 0);
    // write burst against slow credits, then read it back
    for (int i = 0; i < 4; i++)
      add_row(OP_WR, 32'h0000_4060 + 32'(4 * i), 32'h1111_0000 + 32'(i), 1'b0, 1'b0,
              '0, 1'b0, 0);
    for (int i = 0; i < 4; i++)
      add_row(OP_RD, 32'h0000_4060 + 32'(4 * i), '0, 1'b0, 1'b0,
              32'h1111_0000 + 32'(i), 1'b0, 1);

    repeat (3) @(posedge CPU_CLK);
    RST_CPU <= 1'b0;

    for (int i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      wait_idle(ok);
      if (!ok)
      begin
        $display("row %0d: timed out waiting for the cache to go idle", i);
        timed_out = 1'b1;
        break;
      end
      errs_before   = err_cnt;
      reads_before  = read_cnt;
      cpu_req       <= 1'b1;
      cpu_we        <= (r.op == OP_WR);
      cpu_tlb_we    <= (r.op == OP_TLB);
      cpu_addr      <= r.addr;
      cpu_wdata     <= r.wdata;
      vmem_en       <= r.vmem;
      cache_inhibit <= r.inh;
      @(posedge CPU_CLK);                      // accepted here
      cpu_req <= 1'b0;
      wait_response(ok);
      if (!ok)
      begin
        $display("row %0d: timed out waiting for a cpu response", i);
        timed_out = 1'b1;
        break;
      end
      if (r.op == OP_RD && !r.exp_fault)
        check_value("cpu_rdata", cpu_rdata, r.exp_data);
      check_value("cpu_fault", 32'(cpu_fault), 32'(r.exp_fault));
      check_value("mem read requests", 32'(read_cnt - reads_before), 32'(r.exp_reads));
      if (err_cnt == errs_before)
      begin
        pass_cnt++;
        $display("row %0d op %0d addr 0x%08h: ok", i, r.op, r.addr);
      end
      else
      begin
        fail_cnt++;
        $display("row %0d op %0d addr 0x%08h: mismatch", i, r.op, r.addr);
      end
    end

    $display("rows passed: %0d, rows failed: %0d", pass_cnt, fail_cnt);
    if (timed_out || fail_cnt != 0)
      $display("TEST RESULT: FAIL");
    else
      $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
common/snowball_pkg.sv
common/lookup_if.sv
cache/cache_array.sv
cache/tlb_array.sv
src/cache_ctrl.sv
src/snowball_cache_top.sv
test/cache_checker.sv
test/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module cache_tb -f sim.f --Mdir obj_dir -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
